// ==== design/fetch_pkg.sv ====
package fetch_pkg;

    // address and pc width
    localparam int ADDR_W = 32;

    // instruction word width
    localparam int INST_W = 32;

    // pc step between sequential fetches
    localparam logic [ADDR_W-1:0] INST_BYTES = 32'd4;

    // first fetch address out of reset
    localparam logic [ADDR_W-1:0] RST_PC = 32'h8000_0000;

    // redirect from execute, single cycle pulse
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] target;
    } redirect_t;

    // one outstanding request
    // live drops once a redirect makes the request stale
    typedef struct packed {
        logic              live;
        logic [ADDR_W-1:0] pc;
    } fetch_tag_t;

    // pc and instruction handed to decode
    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        logic [INST_W-1:0] inst;
    } fetch_out_t;

endpackage

// ==== design/fetch_fifo.sv ====
`timescale 1ns/1ns

module fetch_fifo #(
    parameter int FETCH_DEPTH = 4,
    parameter int DATA_W      = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push_valid,
    output logic              push_ready,
    input  logic [DATA_W-1:0] push_data,
    output logic              head_valid,
    output logic [DATA_W-1:0] head_data,
    input  logic              pop
);

    // power of two depth
    localparam int PTR_W = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;
    localparam int CNT_W = $clog2(FETCH_DEPTH + 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FETCH_DEPTH);

    logic [DATA_W-1:0] mem [FETCH_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              push_fire;

    assign push_ready = (count_q != CNT_FULL);
    assign push_fire  = push_valid && push_ready;
    assign head_valid = (count_q != '0);
    assign head_data  = mem[rd_ptr_q];

    // pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // count moves only on push xor pop
            if (push_fire && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (!push_fire && pop) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr_q] <= push_data;
        end
    end

    // pop only against a valid head
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> head_valid);

endmodule

// ==== design/fetch_addr_gen.sv ====
`timescale 1ns/1ns

module fetch_addr_gen #(
    parameter int FETCH_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  fetch_pkg::redirect_t         redir,
    output logic                         ar_valid,
    output logic [fetch_pkg::ADDR_W-1:0] ar_addr,
    input  logic                         ar_ready,
    output fetch_pkg::fetch_tag_t        tag_head,
    output logic                         tag_valid,
    input  logic                         tag_pop
);

    // depth is a power of two, pointers wrap on their own
    localparam int PTR_W = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;
    localparam int CNT_W = $clog2(FETCH_DEPTH + 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FETCH_DEPTH);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_FULL
    } state_t;

    state_t                       state_q;
    state_t                       state_d;
    logic [fetch_pkg::ADDR_W-1:0] pc_q;
    logic                         ar_fire;

    // tag queue of outstanding request pcs
    fetch_pkg::fetch_tag_t        tag_mem [FETCH_DEPTH];
    logic [PTR_W-1:0]             wr_ptr_q;
    logic [PTR_W-1:0]             rd_ptr_q;
    logic [CNT_W-1:0]             count_q;
    logic [CNT_W-1:0]             count_d;

    // address only offered while requesting
    assign ar_valid = (state_q == S_REQ);
    assign ar_addr  = pc_q;
    assign ar_fire  = ar_valid && ar_ready;

    // occupancy after this cycle's push and pop
    always_comb begin
        count_d = count_q;
        if (ar_fire && !tag_pop) begin
            count_d = count_q + 1'b1;
        end else if (!ar_fire && tag_pop) begin
            count_d = count_q - 1'b1;
        end
    end

    // idle for one cycle after reset, then request until the queue fills
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: state_d = S_REQ;
            S_REQ: begin
                if (ar_fire && count_d == CNT_FULL) begin
                    state_d = S_FULL;
                end
            end
            // a pop frees one slot
            S_FULL: begin
                if (tag_pop) begin
                    state_d = S_REQ;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= S_IDLE;
            pc_q     <= fetch_pkg::RST_PC;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            state_q <= state_d;
            count_q <= count_d;
            // redirect target wins over the sequential step
            if (redir.valid) begin
                pc_q <= redir.target;
            end else if (ar_fire) begin
                pc_q <= pc_q + fetch_pkg::INST_BYTES;
            end
            if (ar_fire) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (tag_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // redirect kills everything held
    // a push in the redirect cycle enters already dead
    always_ff @(posedge clk) begin
        if (redir.valid) begin
            for (int i = 0; i < FETCH_DEPTH; i++) begin
                tag_mem[i].live <= 1'b0;
            end
        end
        if (ar_fire) begin
            tag_mem[wr_ptr_q] <= '{live: !redir.valid, pc: pc_q};
        end
    end

    assign tag_head  = tag_mem[rd_ptr_q];
    assign tag_valid = (count_q != '0);

    // address held until accepted, unless execute redirects
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready && !redir.valid |=> ar_valid && $stable(ar_addr));

    // pair stage never pops an empty tag queue
    a_tag_pop: assert property (@(posedge clk) disable iff (!rst_n)
        tag_pop |-> tag_valid);

endmodule

// ==== design/fetch_pair_stage.sv ====
`timescale 1ns/1ns

module fetch_pair_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  fetch_pkg::redirect_t         redir,
    input  fetch_pkg::fetch_tag_t        tag_head,
    input  logic                         tag_valid,
    output logic                         tag_pop,
    input  logic [fetch_pkg::INST_W-1:0] inst_head,
    input  logic                         inst_valid,
    output logic                         inst_pop,
    output logic                         out_valid,
    output fetch_pkg::fetch_out_t        out,
    input  logic                         out_ready
);

    logic                  out_valid_q;
    fetch_pkg::fetch_out_t out_q;
    logic                  pair_avail;
    logic                  can_load;
    logic                  load;
    logic                  pair_pop;

    // both heads present
    assign pair_avail = tag_valid && inst_valid;

    // register empty or draining this cycle
    assign can_load = !out_valid_q || out_ready;

    // dead pairs and pairs caught by a redirect are discarded on the spot
    assign pair_pop = pair_avail && (!tag_head.live || redir.valid || can_load);
    assign load     = pair_avail && tag_head.live && !redir.valid && can_load;

    // both queues always advance together
    assign tag_pop  = pair_pop;
    assign inst_pop = pair_pop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
        end else if (redir.valid) begin
            // flush decode output
            out_valid_q <= 1'b0;
        end else if (load) begin
            out_valid_q <= 1'b1;
        end else if (out_ready) begin
            out_valid_q <= 1'b0;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (load) begin
            out_q <= '{pc: tag_head.pc, inst: inst_head};
        end
    end

    assign out_valid = out_valid_q;
    assign out       = out_q;

    // decode sees a steady pair until it takes it
    // redirect may still flush it
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready && !redir.valid |=> out_valid && $stable(out));

endmodule

// ==== design/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top #(
    parameter int FETCH_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  fetch_pkg::redirect_t         redir,
    output logic                         ar_valid,
    output logic [fetch_pkg::ADDR_W-1:0] ar_addr,
    input  logic                         ar_ready,
    input  logic                         r_valid,
    input  logic [fetch_pkg::INST_W-1:0] r_data,
    output logic                         r_ready,
    output logic                         out_valid,
    output fetch_pkg::fetch_out_t        out,
    input  logic                         out_ready
);

    // address side to pairing stage
    fetch_pkg::fetch_tag_t        tag_head;
    logic                         tag_valid;
    logic                         tag_pop;

    // data side to pairing stage
    logic [fetch_pkg::INST_W-1:0] inst_head;
    logic                         inst_valid;
    logic                         inst_pop;

    // request generator and tag queue
    fetch_addr_gen #(
        .FETCH_DEPTH(FETCH_DEPTH)
    ) u_addr_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .redir    (redir),
        .ar_valid (ar_valid),
        .ar_addr  (ar_addr),
        .ar_ready (ar_ready),
        .tag_head (tag_head),
        .tag_valid(tag_valid),
        .tag_pop  (tag_pop)
    );

    // returned words, never deeper than the tag queue
    fetch_fifo #(
        .FETCH_DEPTH(FETCH_DEPTH),
        .DATA_W     (fetch_pkg::INST_W)
    ) u_inst_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push_valid(r_valid),
        .push_ready(r_ready),
        .push_data (r_data),
        .head_valid(inst_valid),
        .head_data (inst_head),
        .pop       (inst_pop)
    );

    // pc and word pairing, decode output register
    fetch_pair_stage u_pair (
        .clk       (clk),
        .rst_n     (rst_n),
        .redir     (redir),
        .tag_head  (tag_head),
        .tag_valid (tag_valid),
        .tag_pop   (tag_pop),
        .inst_head (inst_head),
        .inst_valid(inst_valid),
        .inst_pop  (inst_pop),
        .out_valid (out_valid),
        .out       (out),
        .out_ready (out_ready)
    );

endmodule

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset held for a fixed number of edges, released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

// ==== verification/tb_mem_model.sv ====
`timescale 1ns/1ns

module tb_mem_model #(
    parameter logic [31:0] XOR_KEY   = 32'h1357_9bdf,
    parameter int          MAX_DELAY = 3
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ar_valid,
    input  logic [31:0] ar_addr,
    output logic        ar_ready,
    output logic        r_valid,
    output logic [31:0] r_data,
    input  logic        r_ready
);

    integer      seed = 32'h118f;
    int          cycle = 0;
    int          delay;
    // accepted addresses oldest first with the cycle each may return
    logic [31:0] addr_q [$];
    int          due_q [$];

    initial begin
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        forever begin
            @(posedge clk);
            cycle++;
            if (rst_n !== 1'b1) begin
                addr_q.delete();
                due_q.delete();
            end else begin
                // word taken at this edge
                if (r_valid && r_ready) begin
                    void'(addr_q.pop_front());
                    void'(due_q.pop_front());
                end
                // address taken at this edge gets its latency now
                if (ar_valid && ar_ready) begin
                    delay = $unsigned($random(seed)) % (MAX_DELAY + 1);
                    addr_q.push_back(ar_addr);
                    // latency runs from the later of acceptance and the word ahead
                    if (due_q.size() != 0 && due_q[$] > cycle) begin
                        due_q.push_back(due_q[$] + delay);
                    end else begin
                        due_q.push_back(cycle + delay);
                    end
                end
            end
            #2;
            // accept roughly three addresses in four
            ar_ready = (rst_n === 1'b1) && (($random(seed) & 32'd3) != 0);
            // in order return from the head only
            if (addr_q.size() != 0 && due_q[0] <= cycle) begin
                r_valid = 1'b1;
                r_data  = addr_q[0] ^ XOR_KEY;
            end else begin
                r_valid = 1'b0;
                r_data  = '0;
            end
        end
    end

endmodule

// ==== verification/tb_fetch.sv ====
`timescale 1ns/1ns

module tb_fetch;

    localparam int          FETCH_DEPTH = 4;
    localparam logic [31:0] MEM_XOR     = 32'h1357_9bdf;
    localparam int          NUM_ROWS    = 9;

    // per row the output count then out_ready duty then redirect target with 0 for none
    typedef struct packed {
        logic [31:0] count;
        logic        rand_ready;
        logic [31:0] target;
    } row_t;

    logic                         clk;
    logic                         rst_n;
    fetch_pkg::redirect_t         redir;
    logic                         ar_valid;
    logic [fetch_pkg::ADDR_W-1:0] ar_addr;
    logic                         ar_ready;
    logic                         r_valid;
    logic [fetch_pkg::INST_W-1:0] r_data;
    logic                         r_ready;
    logic                         out_valid;
    fetch_pkg::fetch_out_t        out;
    logic                         out_ready;

    row_t                  rows [NUM_ROWS];
    integer                seed = 32'h118f;
    int                    errors = 0;
    int                    checked = 0;
    int                    cycles = 0;
    int                    timeout_limit = 100;
    int                    total = 0;
    int                    accepted = 0;
    int                    returned = 0;
    logic [31:0]           exp_pc;
    logic                  hold_pending = 1'b0;
    fetch_pkg::fetch_out_t held_out;

    tb_clk_gen #(.HALF_PERIOD(10), .RESET_CYCLES(10)) u_clk_gen (.clk(clk), .rst_n(rst_n));

    tb_mem_model #(.XOR_KEY(MEM_XOR)) u_mem (
        .clk(clk), .rst_n(rst_n), .ar_valid(ar_valid), .ar_addr(ar_addr), .ar_ready(ar_ready),
        .r_valid(r_valid), .r_data(r_data), .r_ready(r_ready)
    );

    fetch_top #(.FETCH_DEPTH(FETCH_DEPTH)) u_dut (
        .clk(clk), .rst_n(rst_n), .redir(redir), .ar_valid(ar_valid), .ar_addr(ar_addr),
        .ar_ready(ar_ready), .r_valid(r_valid), .r_data(r_data), .r_ready(r_ready),
        .out_valid(out_valid), .out(out), .out_ready(out_ready)
    );

    // quiet outputs in reset and one cycle after and then the reset pc
    task automatic check_reset();
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            assert (!ar_valid) else begin
                $display("FAIL ar_valid expected 0 actual %h", ar_valid);
                errors++;
            end
            assert (!out_valid) else begin
                $display("FAIL out_valid expected 0 actual %h", out_valid);
                errors++;
            end
        end
        @(posedge clk);
        assert (ar_valid) else begin
            $display("FAIL ar_valid expected 1 actual %h", ar_valid);
            errors++;
        end
        assert (ar_addr == fetch_pkg::RST_PC) else begin
            $display("FAIL ar_addr expected %h actual %h", fetch_pkg::RST_PC, ar_addr);
            errors++;
        end
    endtask

    // one transfer on out against the sequential model
    task automatic check_output();
        logic [31:0] exp_inst;
        exp_inst = exp_pc ^ MEM_XOR;
        assert (out.pc == exp_pc) else begin
            $display("FAIL out.pc expected %h actual %h", exp_pc, out.pc);
            errors++;
        end
        assert (out.inst == exp_inst) else begin
            $display("FAIL out.inst expected %h actual %h", exp_inst, out.inst);
            errors++;
        end
        exp_pc = exp_pc + fetch_pkg::INST_BYTES;
        checked++;
    endtask

    // entered and left 2 ns after an edge with out_ready low on exit
    task automatic take_outputs(input logic [31:0] count, input logic rand_ready);
        int taken;
        taken = 0;
        while (taken < count) begin
            out_ready = rand_ready ? (($random(seed) & 32'd1) != 0) : 1'b1;
            @(posedge clk);
            if (out_valid && out_ready) begin
                check_output();
                taken++;
            end
            #2;
        end
        out_ready = 1'b0;
    endtask

    // single cycle pulse then the stream restarts at dest
    task automatic issue_redirect(input logic [31:0] dest);
        redir = '{valid: 1'b1, target: dest};
        @(posedge clk);
        #2;
        redir = '0;
        exp_pc = dest;
        // output register flushed in the cycle after the pulse
        @(posedge clk);
        assert (!out_valid) else begin
            $display("FAIL out_valid expected 0 actual %h", out_valid);
            errors++;
        end
        // next address already at the target
        assert (ar_addr == dest) else begin
            $display("FAIL ar_addr expected %h actual %h", dest, ar_addr);
            errors++;
        end
        #2;
    endtask

    // out held steady while stalled unless a redirect flushes it
    always @(posedge clk) begin
        if (rst_n !== 1'b1) begin
            hold_pending = 1'b0;
        end else begin
            if (hold_pending) begin
                assert (out_valid) else begin
                    $display("FAIL out_valid expected 1 actual %h", out_valid);
                    errors++;
                end
                assert (out == held_out) else begin
                    $display("FAIL out expected %h actual %h", held_out, out);
                    errors++;
                end
            end
            hold_pending = out_valid && !out_ready && !redir.valid;
            held_out     = out;
        end
    end

    // accepted minus returned as counted at the ports
    always @(posedge clk) begin
        if (rst_n === 1'b1) begin
            if (ar_valid && ar_ready) begin
                accepted++;
            end
            if (r_valid && r_ready) begin
                returned++;
            end
            assert (accepted - returned <= FETCH_DEPTH) else begin
                $display("too many requests in flight: %0d accepted, %0d returned",
                         accepted, returned);
                errors++;
            end
            // returned words never refused
            if (r_valid) begin
                assert (r_ready) else begin
                    $display("FAIL r_ready expected 1 actual %h", r_ready);
                    errors++;
                end
            end
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_limit) begin
            $display("timeout after %0d cycles with %0d of %0d outputs seen",
                     cycles, checked, total);
            $display("outputs checked: %0d, errors: %0d", checked, errors);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        redir     = '0;
        out_ready = 1'b0;
        exp_pc    = fetch_pkg::RST_PC;
        rows = '{
            '{count: 6,  rand_ready: 1'b0, target: 32'h8000_1000},
            '{count: 8,  rand_ready: 1'b1, target: 32'h8000_0200},
            '{count: 5,  rand_ready: 1'b1, target: 32'h0000_0000},
            '{count: 3,  rand_ready: 1'b0, target: 32'h9000_0040},
            '{count: 1,  rand_ready: 1'b0, target: 32'h8000_0004},
            // back to back redirects
            '{count: 0,  rand_ready: 1'b0, target: 32'ha000_0100},
            '{count: 12, rand_ready: 1'b1, target: 32'ha000_0ff0},
            '{count: 20, rand_ready: 1'b1, target: 32'h0000_0000},
            '{count: 16, rand_ready: 1'b0, target: 32'h0000_0000}
        };
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += rows[i].count;
        end
        timeout_limit = 20 * total + 100;
        check_reset();
        #2;
        for (int i = 0; i < NUM_ROWS; i++) begin
            take_outputs(rows[i].count, rows[i].rand_ready);
            if (rows[i].target != '0) begin
                issue_redirect(rows[i].target);
            end
        end
        $display("outputs checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
design/fetch_pkg.sv
design/fetch_fifo.sv
design/fetch_addr_gen.sv
design/fetch_pair_stage.sv
design/fetch_top.sv
verification/tb_clk_gen.sv
verification/tb_mem_model.sv
verification/tb_fetch.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_fetch -f filelist.f
./obj_dir/Vtb_fetch | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    exit 0
else
    exit 1
fi
